// ==== lgen.f ====
+incdir+source
source/lgen_pkg.sv
source/lgen_regs.sv
source/lgen_table.sv
source/lgen_seq.sv
source/lgen_top.sv
tb/lgen_tb.sv

// ==== run_lgen.sh ====
#!/bin/sh
# build and run the lgen testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f lgen.f --top-module lgen_tb -o lgen_sim
out=$(./obj_dir/lgen_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// ==== tb/lgen_tb.sv ====
/*
  self-checking testbench for the logic pattern generator
  a model here predicts every stream beat from the table and the config
  stimulus and back-pressure are random from one fixed seed
*/
`timescale 1ns/10ps
`include "lgen_defs.svh"

module lgen_tb
  import lgen_pkg::*;
();

  logic        bus;
  logic        ctl_rst;
  logic        req;
  bus_req_t    bus_req;
  logic [3:0]  evn_ext;
  logic        ready;
  logic        ack;
  logic [31:0] rdata;
  logic        irq;
  logic        valid;
  stream_t     sto;

  // model of table and playback config
  logic [7:0]  tbl_mdl [1024];
  logic [17:0] mdl_siz;
  logic [17:0] mdl_off;
  logic [17:0] mdl_ste;
  logic [7:0]  mdl_msk;
  logic [7:0]  mdl_val;
  // expected beats, popped by the monitor
  stream_t     exp_q [$];
  stream_t     exp_beat;
  // beat with nothing expected is an error when set
  logic        strict;
  string       test_name;
  int          cyc;
  int          ack_cyc;
  int          last_vld;

  lgen_top u_lgen_top (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .req     (req),
    .bus_req (bus_req),
    .ack     (ack),
    .rdata   (rdata),
    .irq     (irq),
    .evn_ext (evn_ext),
    .ready   (ready),
    .valid   (valid),
    .sto     (sto)
  );

  // 40 ns period
  always #20 bus = ~bus;

  // counts on the falling edge, stable for rising-edge code
  always @(negedge bus) cyc <= cyc + 1;

  // random back-pressure, high about 3 cycles in 4
  always @(posedge bus) ready <= ($urandom % 4) != 0;

  //////////////////////////////////////////////////////////////////////
  // failure reporting and checks
  //////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: %s: timed out waiting for %s", test_name, what);
    end_with_failure();
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("[FAIL] %s, %s: expected %0h, actual %0h", test_name, what, exp, got);
      end_with_failure();
    end
  endtask

  // stream monitor, sees the values from before the edge
  always @(posedge bus) begin
    if (!ctl_rst && valid) last_vld = cyc;
    if (!ctl_rst && valid && ready) begin
      if (exp_q.size() > 0) begin
        exp_beat = exp_q.pop_front();
        check_eq("stream beat {dat,lst}", 32'(exp_beat), 32'(sto));
      end else begin
        assert (!strict) else begin
          $display("ERROR: %s: stream beat after the last expected one", test_name);
          end_with_failure();
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // cpu port, four-phase
  //////////////////////////////////////////////////////////////////////

  task automatic bus_xfer(input logic wr, input logic [10:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rd);
    int n;
    @(posedge bus);
    req     <= 1'b1;
    bus_req <= '{wr: wr, addr: addr, wdata: wdata};
    n = 0;
    do begin
      @(posedge bus);
      n++;
      if (n > 20) report_timeout("ack to rise");
    end while (!ack);
    // ack one cycle after req is seen
    check_eq("ack rise cycles", 32'd2, 32'(n));
    ack_cyc = cyc;
    rd      = rdata;
    req     <= 1'b0;
    n = 0;
    do begin
      @(posedge bus);
      n++;
      if (n > 20) report_timeout("ack to fall");
    end while (ack);
    check_eq("ack fall cycles", 32'd2, 32'(n));
  endtask

  task automatic write_reg(input logic [10:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_xfer(1'b1, addr, data, unused);
  endtask

  task automatic check_reg(input logic [10:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_xfer(1'b0, addr, 32'h0, rd);
    check_eq($sformatf("register %03h", addr), exp, rd);
  endtask

  // writable config first, read-only and event registers last
  function automatic logic [10:0] reg_addr(input int i);
    case (i)
      0:  return `LGEN_REG_IRQ_ENA;
      1:  return `LGEN_REG_SEL_RST;
      2:  return `LGEN_REG_SEL_STR;
      3:  return `LGEN_REG_SEL_STP;
      4:  return `LGEN_REG_SEL_TRG;
      5:  return `LGEN_REG_SIZ;
      6:  return `LGEN_REG_OFF;
      7:  return `LGEN_REG_STE;
      8:  return `LGEN_REG_BMODE;
      9:  return `LGEN_REG_BDL;
      10: return `LGEN_REG_BLN;
      11: return `LGEN_REG_BNM;
      12: return `LGEN_REG_MSK;
      13: return `LGEN_REG_VAL;
      14: return `LGEN_REG_CTL;
      15: return `LGEN_REG_IRQ_STS;
      16: return `LGEN_REG_STS_BLN;
      default: return `LGEN_REG_STS_BNM;
    endcase
  endfunction

  // implemented bits per register
  function automatic logic [31:0] reg_mask(input logic [10:0] addr);
    case (addr)
      `LGEN_REG_IRQ_ENA: return 32'hf;
      `LGEN_REG_SEL_RST, `LGEN_REG_SEL_STR: return 32'h1f;
      `LGEN_REG_SEL_STP, `LGEN_REG_SEL_TRG: return 32'h1f;
      `LGEN_REG_SIZ, `LGEN_REG_OFF, `LGEN_REG_STE: return 32'h3ffff;
      `LGEN_REG_BMODE: return 32'h3;
      `LGEN_REG_BDL: return 32'h3ff;
      `LGEN_REG_BLN, `LGEN_REG_BNM: return 32'hffff;
      `LGEN_REG_MSK, `LGEN_REG_VAL: return 32'hff;
      default: return 32'h0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // table bits under the mask, forced value elsewhere
  function automatic logic [7:0] shape(input logic [7:0] raw);
    return (raw & mdl_msk) | (mdl_val & ~mdl_msk);
  endfunction

  // step, one wrap by siz
  function automatic logic [17:0] next_ptr(input logic [17:0] p);
    logic [18:0] s;
    s = {1'b0, p} + {1'b0, mdl_ste};
    if (s >= {1'b0, mdl_siz}) s = s - {1'b0, mdl_siz};
    return s[17:0];
  endfunction

  task automatic plan_continuous(input int n);
    logic [17:0] p;
    stream_t     beat;
    p = mdl_off;
    for (int i = 0; i < n; i++) begin
      beat.dat = shape(tbl_mdl[p[17:8]]);
      beat.lst = 1'b0;
      exp_q.push_back(beat);
      p = next_ptr(p);
    end
  endtask

  task automatic plan_burst(input int bdl, input int bln, input int bnm);
    logic [17:0] p;
    stream_t     beat;
    for (int b = 0; b < bnm; b++) begin
      // every burst restarts at off
      p = mdl_off;
      for (int i = 0; i < bdl; i++) begin
        beat.dat = shape(tbl_mdl[p[17:8]]);
        beat.lst = (i == bdl - 1);
        exp_q.push_back(beat);
        p = next_ptr(p);
      end
      // gap plays data 0
      for (int g = 0; g < bln; g++) begin
        beat.dat = shape(8'h00);
        beat.lst = 1'b0;
        exp_q.push_back(beat);
      end
    end
  endtask

  task automatic drain_stream(input int limit);
    int n;
    n = 0;
    while (exp_q.size() > 0) begin
      @(negedge bus);
      n++;
      if (n > limit) report_timeout("the expected stream beats");
    end
  endtask

  task automatic fill_table();
    logic [7:0] d;
    for (int i = 0; i < 1024; i++) begin
      d = 8'($urandom);
      tbl_mdl[i] = d;
      write_reg({1'b1, 10'(i)}, 32'(d));
    end
  endtask

  // 64 to 255 entries with a fraction, step of 0.5 to 3.5 entries
  task automatic random_playback();
    mdl_siz = 18'(((64 + $urandom % 192) << 8) | ($urandom % 256));
    mdl_off = 18'($urandom % 32'(mdl_siz));
    mdl_ste = 18'(128 + $urandom % 768);
    write_reg(`LGEN_REG_SIZ, 32'(mdl_siz));
    write_reg(`LGEN_REG_OFF, 32'(mdl_off));
    write_reg(`LGEN_REG_STE, 32'(mdl_ste));
  endtask

  task automatic set_shape(input logic [7:0] msk, input logic [7:0] val);
    mdl_msk = msk;
    mdl_val = val;
    write_reg(`LGEN_REG_MSK, 32'(msk));
    write_reg(`LGEN_REG_VAL, 32'(val));
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (irq !== level) begin
      @(posedge bus);
      n++;
      if (n > 20) report_timeout("irq to change");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] data;
    int          k;
    int          bdl;
    int          bln;
    int          bnm;
    void'($urandom(11528));
    bus      = 1'b0;
    ctl_rst  <= 1'b1;
    req      <= 1'b0;
    bus_req  <= '0;
    evn_ext  <= '0;
    ready    <= 1'b0;
    cyc      <= 0;
    ack_cyc  = 0;
    last_vld = 0;
    strict   = 1'b0;
    mdl_msk  = 8'hff;
    mdl_val  = 8'h00;
    repeat (3) @(posedge bus);
    ctl_rst <= 1'b0;

    test_name = "register reset and readback";
    for (int i = 0; i < 18; i++) check_reg(reg_addr(i), 32'h0);
    for (int i = 0; i < 14; i++) begin
      data = $urandom;
      write_reg(reg_addr(i), data);
      check_reg(reg_addr(i), data & reg_mask(reg_addr(i)));
    end

    // software source for every function
    test_name = "continuous playback";
    fill_table();
    write_reg(`LGEN_REG_BMODE, 32'h0);
    write_reg(`LGEN_REG_IRQ_ENA, 32'h0);
    for (int i = 1; i < 5; i++) write_reg(reg_addr(i), 32'h1);
    set_shape(8'hff, 8'h00);
    random_playback();
    // enough beats to pass siz at least once
    plan_continuous(600);
    write_reg(`LGEN_REG_CTL, 32'h2);
    write_reg(`LGEN_REG_CTL, 32'h8);
    drain_stream(20000);
    write_reg(`LGEN_REG_CTL, 32'h4);

    test_name = "mask and value";
    set_shape(8'($urandom), 8'($urandom));
    random_playback();
    plan_continuous(200);
    write_reg(`LGEN_REG_CTL, 32'h2);
    write_reg(`LGEN_REG_CTL, 32'h8);
    drain_stream(20000);
    write_reg(`LGEN_REG_CTL, 32'h4);

    test_name = "burst mode";
    bdl = 3 + $urandom % 10;
    bln = $urandom % 6;
    bnm = 2 + $urandom % 3;
    write_reg(`LGEN_REG_BDL, 32'(bdl));
    write_reg(`LGEN_REG_BLN, 32'(bln));
    write_reg(`LGEN_REG_BNM, 32'(bnm));
    write_reg(`LGEN_REG_BMODE, 32'h1);
    plan_burst(bdl, bln, bnm);
    strict = 1'b1;
    write_reg(`LGEN_REG_CTL, 32'h2);
    write_reg(`LGEN_REG_CTL, 32'h8);
    drain_stream(20000);
    // quiet window, the monitor flags any extra beat
    repeat (200) @(posedge bus);
    check_reg(`LGEN_REG_STS_BNM, 32'(bnm));
    // stopped, not running
    check_reg(`LGEN_REG_CTL, 32'h4);
    strict = 1'b0;
    write_reg(`LGEN_REG_BMODE, 32'h0);

    test_name = "external trigger and stop";
    k = $urandom % 4;
    // external lines sit above the software bit
    write_reg(`LGEN_REG_SEL_TRG, 32'(1 << (k + 1)));
    write_reg(`LGEN_REG_CTL, 32'h2);
    check_reg(`LGEN_REG_CTL, 32'h1);
    plan_continuous(60);
    @(posedge bus);
    evn_ext <= 4'(1 << k);
    @(posedge bus);
    evn_ext <= '0;
    drain_stream(5000);
    write_reg(`LGEN_REG_CTL, 32'h4);
    @(negedge bus);
    check_eq("valid after stop", 32'h0, 32'(valid));
    // valid stays low once dropped
    repeat (10) @(negedge bus);
    // ack_cyc is taken one edge after ack rises
    assert (last_vld <= ack_cyc + 2) else begin
      $display("ERROR: %s: valid was high more than 3 cycles after the stop ack",
               test_name);
      end_with_failure();
    end
    write_reg(`LGEN_REG_SEL_TRG, 32'h1);

    test_name = "interrupts";
    write_reg(`LGEN_REG_IRQ_STS, 32'hf);
    // only the start cause raises irq
    write_reg(`LGEN_REG_IRQ_ENA, 32'h2);
    write_reg(`LGEN_REG_CTL, 32'h1);
    check_reg(`LGEN_REG_IRQ_STS, 32'h1);
    check_eq("irq with no enabled cause", 32'h0, 32'(irq));
    write_reg(`LGEN_REG_CTL, 32'h2);
    wait_irq(1'b1);
    check_reg(`LGEN_REG_IRQ_STS, 32'h3);
    write_reg(`LGEN_REG_IRQ_STS, 32'h3);
    wait_irq(1'b0);
    check_reg(`LGEN_REG_IRQ_STS, 32'h0);
    write_reg(`LGEN_REG_CTL, 32'h4);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== source/lgen_top.sv ====
/*
  logic pattern generator top
  cpu port is four-phase req/ack, the stream is valid/ready
*/
`timescale 1ns/10ps
`include "lgen_defs.svh"

module lgen_top
  import lgen_pkg::*;
(
  input  logic        bus,
  input  logic        ctl_rst,
  // cpu port
  input  logic        req,
  input  bus_req_t    bus_req,
  output logic        ack,
  output logic [31:0] rdata,
  output logic        irq,
  // external event lines
  input  logic [3:0]  evn_ext,
  // stream out
  input  logic        ready,
  output logic        valid,
  output stream_t     sto
);

  lgen_cfg_t            cfg;
  lgen_ctl_t            ctl;
  lgen_sts_t            sts;
  tbl_wr_t              tbl_wr;
  // table read path
  logic [`LGEN_CWM-1:0] rd_idx;
  logic [`LGEN_DW-1:0]  rd_data;

  //////////////////////////////////////////////////////////////////////
  // registers, table, sequencer
  //////////////////////////////////////////////////////////////////////

  lgen_regs u_regs (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .req     (req),
    .bus_req (bus_req),
    .evn_ext (evn_ext),
    .sts     (sts),
    .ack     (ack),
    .rdata   (rdata),
    .cfg     (cfg),
    .ctl     (ctl),
    .tbl_wr  (tbl_wr),
    .irq     (irq)
  );

  lgen_table u_table (
    .bus     (bus),
    .tbl_wr  (tbl_wr),
    .rd_idx  (rd_idx),
    .rd_data (rd_data)
  );

  lgen_seq u_seq (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .cfg     (cfg),
    .ctl     (ctl),
    .rd_data (rd_data),
    .ready   (ready),
    .sts     (sts),
    .rd_idx  (rd_idx),
    .valid   (valid),
    .sto     (sto)
  );

endmodule

// ==== source/lgen_seq.sv ====
/*
  playback sequencer, pointer is 10.8 fixed point wrapping at siz
  a bdl of 0 plays 1024 samples, a bnm of 0 plays 65536 bursts
  stop and reset events drop valid even when a sample is waiting
*/
`timescale 1ns/10ps
`include "lgen_defs.svh"

module lgen_seq
  import lgen_pkg::*;
(
  input  logic                 bus,
  input  logic                 ctl_rst,
  input  lgen_cfg_t            cfg,
  input  lgen_ctl_t            ctl,
  input  logic [`LGEN_DW-1:0]  rd_data,
  input  logic                 ready,
  output lgen_sts_t            sts,
  output logic [`LGEN_CWM-1:0] rd_idx,
  output logic                 valid,
  output stream_t              sto
);

  seq_state_t           state;
  logic [`LGEN_CW-1:0]  ptr;
  // spare top bit keeps the carry of ptr + ste
  logic [`LGEN_CW:0]    ptr_sum;
  logic [`LGEN_CW:0]    ptr_dif;
  logic [`LGEN_CW-1:0]  ptr_nxt;
  // burst counters
  logic [`LGEN_CWM-1:0] cnt_dat;
  logic [`LGEN_CWL-1:0] cnt_gap;
  logic [`LGEN_CWN-1:0] cnt_bur;
  logic [`LGEN_CWN-1:0] bur_nxt;
  logic [`LGEN_CWM-1:0] bdl_lst;
  logic [`LGEN_CWL-1:0] bln_lst;
  logic                 stp_flg;
  logic                 act;
  logic                 adv;
  logic                 dat_end;
  logic                 gap_end;
  logic                 bur_end;
  logic                 bur_done;
  logic [`LGEN_DW-1:0]  smp;

  // sample producing states, advance only when the output slot is free
  assign act = (state == SEQ_DATA) || (state == SEQ_GAP);
  assign adv = act && (!valid || ready);

  assign rd_idx = ptr[`LGEN_CW-1:`LGEN_CWF];

  // step, minus siz once past it
  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg.ste};
  assign ptr_dif = ptr_sum - {1'b0, cfg.siz};
  assign ptr_nxt = (ptr_sum >= {1'b0, cfg.siz}) ? ptr_dif[`LGEN_CW-1:0]
                                                : ptr_sum[`LGEN_CW-1:0];

  // burst bookkeeping
  assign bdl_lst  = cfg.bdl - 1'b1;
  assign bln_lst  = cfg.bln - 1'b1;
  assign dat_end  = cfg.ben && (state == SEQ_DATA) && (cnt_dat == bdl_lst);
  assign gap_end  = (state == SEQ_GAP) && (cnt_gap == bln_lst);
  assign bur_end  = adv && ((dat_end && cfg.bln == '0) || gap_end);
  assign bur_nxt  = cnt_bur + 1'b1;
  assign bur_done = !cfg.inf && (bur_nxt == cfg.bnm);

  //////////////////////////////////////////////////////////////////////
  // state, pointer and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      state   <= SEQ_IDLE;
      ptr     <= '0;
      cnt_dat <= '0;
      cnt_gap <= '0;
      cnt_bur <= '0;
      stp_flg <= 1'b0;
    end else if (ctl.rst) begin
      state   <= SEQ_IDLE;
      ptr     <= cfg.off;
      cnt_dat <= '0;
      cnt_gap <= '0;
      cnt_bur <= '0;
      stp_flg <= 1'b0;
    end else if (ctl.stp) begin
      state   <= SEQ_IDLE;
      stp_flg <= 1'b1;
    end else if (bur_end) begin
      // next burst restarts at off
      cnt_bur <= bur_nxt;
      cnt_dat <= '0;
      ptr     <= cfg.off;
      if (bur_done) begin
        state   <= SEQ_IDLE;
        stp_flg <= 1'b1;
      end else begin
        state <= SEQ_DATA;
      end
    end else begin
      case (state)
        SEQ_IDLE: if (ctl.str) begin
          state   <= SEQ_ARMED;
          ptr     <= cfg.off;
          cnt_dat <= '0;
          cnt_gap <= '0;
          cnt_bur <= '0;
          stp_flg <= 1'b0;
        end
        SEQ_ARMED: if (ctl.trg) state <= SEQ_DATA;
        SEQ_DATA: if (adv) begin
          ptr     <= ptr_nxt;
          cnt_dat <= cnt_dat + 1'b1;
          // gap only in burst mode
          if (dat_end) begin
            state   <= SEQ_GAP;
            cnt_gap <= '0;
          end
        end
        SEQ_GAP: if (adv) cnt_gap <= cnt_gap + 1'b1;
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  // gap plays data 0, still passed through mask/value
  assign smp = (state == SEQ_DATA) ? rd_data : '0;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      valid <= 1'b0;
    end else if (ctl.stp || ctl.rst) begin
      valid <= 1'b0;
    end else if (adv) begin
      valid <= 1'b1;
    end else if (ready) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (adv) begin
      sto.dat <= (smp & cfg.msk) | (cfg.val & ~cfg.msk);
      sto.lst <= dat_end;
    end
  end

  assign sts.armed   = (state == SEQ_ARMED);
  assign sts.running = act;
  assign sts.stopped = stp_flg;
  assign sts.bln     = cnt_gap;
  assign sts.bnm     = cnt_bur;

endmodule

// ==== source/lgen_table.sv ====
/*
  waveform table, 1024 samples of 8 bits
  no reset, contents are undefined until written
  the read port is combinational
*/
`timescale 1ns/10ps
`include "lgen_defs.svh"

module lgen_table
  import lgen_pkg::*;
#(
  parameter int unsigned DW = `LGEN_DW,
  parameter int unsigned AW = `LGEN_CWM
)(
  input  logic          bus,
  // cpu side
  input  tbl_wr_t       tbl_wr,
  // generator side
  input  logic [AW-1:0] rd_idx,
  output logic [DW-1:0] rd_data
);

  localparam int unsigned DEPTH = 2 ** AW;

  // sample storage
  logic [DW-1:0] mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // one sample per pulse, done at the end of the cycle
  always_ff @(posedge bus) begin
    if (tbl_wr.en) begin
      mem[tbl_wr.idx] <= tbl_wr.dat;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // sample ready in the same cycle as the index
  // a write and a read of one entry in one cycle returns the old value
  assign rd_data = mem[rd_idx];

endmodule

// ==== source/lgen_regs.sv ====
/*
  cpu port with four-phase req/ack, one access per request
  the waveform table is write-only and reads back as zero
  software events take two cycles from ack to the sequencer state
*/
`timescale 1ns/10ps
`include "lgen_defs.svh"

module lgen_regs
  import lgen_pkg::*;
(
  input  logic        bus,
  input  logic        ctl_rst,
  input  logic        req,
  input  bus_req_t    bus_req,
  input  logic [3:0]  evn_ext,
  input  lgen_sts_t   sts,
  output logic        ack,
  output logic [31:0] rdata,
  output lgen_cfg_t   cfg,
  output lgen_ctl_t   ctl,
  output tbl_wr_t     tbl_wr,
  output logic        irq
);

  typedef enum logic {
    HS_IDLE,
    HS_ACK
  } hs_state_t;

  hs_state_t           hs_state;
  // access strobes
  logic                acc;
  logic                wr_acc;
  logic                wr_tbl;
  logic                wr_reg;
  // software events, {trg, stp, str, rst}
  logic [3:0]          evn_sw;
  logic [3:0]          evn_ext_q;
  // event select masks
  logic [`LGEN_EW-1:0] sel_rst;
  logic [`LGEN_EW-1:0] sel_str;
  logic [`LGEN_EW-1:0] sel_stp;
  logic [`LGEN_EW-1:0] sel_trg;
  // interrupts
  logic [3:0]          irq_ena;
  logic [3:0]          irq_sts;
  logic [3:0]          irq_keep;
  logic [31:0]         rd_mux;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      hs_state <= HS_IDLE;
    end else begin
      case (hs_state)
        HS_IDLE: if (req) hs_state <= HS_ACK;
        HS_ACK:  if (!req) hs_state <= HS_IDLE;
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  assign ack = (hs_state == HS_ACK);
  // single access, on the cycle before ack rises
  assign acc    = req && (hs_state == HS_IDLE);
  assign wr_acc = acc && bus_req.wr;
  assign wr_tbl = wr_acc && bus_req.addr[`LGEN_AW-1];
  assign wr_reg = wr_acc && !bus_req.addr[`LGEN_AW-1];

  // table write pulse, high while ack first is
  always_ff @(posedge bus) begin
    tbl_wr.idx <= bus_req.addr[`LGEN_CWM-1:0];
    tbl_wr.dat <= bus_req.wdata[`LGEN_DW-1:0];
    if (ctl_rst) begin
      tbl_wr.en <= 1'b0;
    end else begin
      tbl_wr.en <= wr_tbl;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      cfg     <= '0;
      irq_ena <= '0;
      sel_rst <= '0;
      sel_str <= '0;
      sel_stp <= '0;
      sel_trg <= '0;
    end else if (wr_reg) begin
      case (bus_req.addr)
        `LGEN_REG_IRQ_ENA: irq_ena <= bus_req.wdata[3:0];
        `LGEN_REG_SEL_RST: sel_rst <= bus_req.wdata[`LGEN_EW-1:0];
        `LGEN_REG_SEL_STR: sel_str <= bus_req.wdata[`LGEN_EW-1:0];
        `LGEN_REG_SEL_STP: sel_stp <= bus_req.wdata[`LGEN_EW-1:0];
        `LGEN_REG_SEL_TRG: sel_trg <= bus_req.wdata[`LGEN_EW-1:0];
        `LGEN_REG_SIZ:     cfg.siz <= bus_req.wdata[`LGEN_CW-1:0];
        `LGEN_REG_OFF:     cfg.off <= bus_req.wdata[`LGEN_CW-1:0];
        `LGEN_REG_STE:     cfg.ste <= bus_req.wdata[`LGEN_CW-1:0];
        `LGEN_REG_BMODE: begin
          cfg.ben <= bus_req.wdata[0];
          cfg.inf <= bus_req.wdata[1];
        end
        `LGEN_REG_BDL:     cfg.bdl <= bus_req.wdata[`LGEN_CWM-1:0];
        `LGEN_REG_BLN:     cfg.bln <= bus_req.wdata[`LGEN_CWL-1:0];
        `LGEN_REG_BNM:     cfg.bnm <= bus_req.wdata[`LGEN_CWN-1:0];
        `LGEN_REG_MSK:     cfg.msk <= bus_req.wdata[`LGEN_DW-1:0];
        `LGEN_REG_VAL:     cfg.val <= bus_req.wdata[`LGEN_DW-1:0];
        default: ;
      endcase
    end
  end

  // readback, ctl shows the sequencer flags
  always_comb begin
    rd_mux = '0;
    case (bus_req.addr)
      `LGEN_REG_CTL:     rd_mux = 32'({sts.stopped, sts.running, sts.armed});
      `LGEN_REG_IRQ_ENA: rd_mux = 32'(irq_ena);
      `LGEN_REG_IRQ_STS: rd_mux = 32'(irq_sts);
      `LGEN_REG_SEL_RST: rd_mux = 32'(sel_rst);
      `LGEN_REG_SEL_STR: rd_mux = 32'(sel_str);
      `LGEN_REG_SEL_STP: rd_mux = 32'(sel_stp);
      `LGEN_REG_SEL_TRG: rd_mux = 32'(sel_trg);
      `LGEN_REG_SIZ:     rd_mux = 32'(cfg.siz);
      `LGEN_REG_OFF:     rd_mux = 32'(cfg.off);
      `LGEN_REG_STE:     rd_mux = 32'(cfg.ste);
      `LGEN_REG_BMODE:   rd_mux = 32'({cfg.inf, cfg.ben});
      `LGEN_REG_BDL:     rd_mux = 32'(cfg.bdl);
      `LGEN_REG_BLN:     rd_mux = 32'(cfg.bln);
      `LGEN_REG_BNM:     rd_mux = 32'(cfg.bnm);
      `LGEN_REG_STS_BLN: rd_mux = 32'(sts.bln);
      `LGEN_REG_STS_BNM: rd_mux = 32'(sts.bnm);
      `LGEN_REG_MSK:     rd_mux = 32'(cfg.msk);
      `LGEN_REG_VAL:     rd_mux = 32'(cfg.val);
      default:           rd_mux = '0;
    endcase
  end

  // held until the next access
  always_ff @(posedge bus) begin
    if (acc) begin
      rdata <= rd_mux;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // events and interrupts
  //////////////////////////////////////////////////////////////////////

  // software pulse, then the event register after it
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      evn_sw    <= '0;
      evn_ext_q <= '0;
      ctl       <= '0;
    end else begin
      evn_sw    <= (wr_reg && bus_req.addr == `LGEN_REG_CTL) ? bus_req.wdata[3:0] : '0;
      evn_ext_q <= evn_ext;
      ctl.rst   <= |({evn_ext_q, evn_sw[0]} & sel_rst);
      ctl.str   <= |({evn_ext_q, evn_sw[1]} & sel_str);
      ctl.stp   <= |({evn_ext_q, evn_sw[2]} & sel_stp);
      ctl.trg   <= |({evn_ext_q, evn_sw[3]} & sel_trg);
    end
  end

  // reset event wipes old causes, then new ones latch
  always_comb begin
    irq_keep = irq_sts;
    if (ctl.rst) begin
      irq_keep = '0;
    end else if (wr_reg && bus_req.addr == `LGEN_REG_IRQ_STS) begin
      irq_keep = irq_sts & ~bus_req.wdata[3:0];
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_sts <= '0;
      irq     <= 1'b0;
    end else begin
      irq_sts <= irq_keep | {ctl.trg, ctl.stp, ctl.str, ctl.rst};
      irq     <= |(irq_sts & irq_ena);
    end
  end

endmodule

// ==== source/lgen_pkg.sv ====
/*
  types shared by the generator RTL and its testbench
  widths come from the macro header
*/
`include "lgen_defs.svh"

package lgen_pkg;

  // cpu request, held stable by the master while req is high
  typedef struct packed {
    logic                wr;
    logic [`LGEN_AW-1:0] addr;
    logic [31:0]         wdata;
  } bus_req_t;

  // one table write, valid for a single cycle
  typedef struct packed {
    logic                 en;
    logic [`LGEN_CWM-1:0] idx;
    logic [`LGEN_DW-1:0]  dat;
  } tbl_wr_t;

  // selected events, one-cycle pulses
  typedef struct packed {
    logic rst;
    logic str;
    logic stp;
    logic trg;
  } lgen_ctl_t;

  // playback configuration
  typedef struct packed {
    // fixed point size, offset and step
    logic [`LGEN_CW-1:0]  siz;
    logic [`LGEN_CW-1:0]  off;
    logic [`LGEN_CW-1:0]  ste;
    // burst mode
    logic                 ben;
    logic                 inf;
    logic [`LGEN_CWM-1:0] bdl;
    logic [`LGEN_CWL-1:0] bln;
    logic [`LGEN_CWN-1:0] bnm;
    // output bits, table where msk is 1, val elsewhere
    logic [`LGEN_DW-1:0]  msk;
    logic [`LGEN_DW-1:0]  val;
  } lgen_cfg_t;

  // sequencer status for readback
  typedef struct packed {
    logic                 armed;
    logic                 running;
    logic                 stopped;
    logic [`LGEN_CWL-1:0] bln;
    logic [`LGEN_CWN-1:0] bnm;
  } lgen_sts_t;

  // stream beat
  typedef struct packed {
    logic [`LGEN_DW-1:0] dat;
    logic                lst;
  } stream_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ARMED,
    SEQ_DATA,
    SEQ_GAP
  } seq_state_t;

endpackage

// ==== source/lgen_defs.svh ====
/*
  widths, depths and register map of the logic pattern generator
  register offsets are byte addresses with address bit 10 clear
  with address bit 10 set, the low 10 address bits index the table
*/
`ifndef LGEN_DEFS_SVH
`define LGEN_DEFS_SVH

// sample width
`define LGEN_DW   8
// pointer, integer part also sets the table depth
`define LGEN_CWM  10
`define LGEN_CWF  8
`define LGEN_CW   18
// burst gap length and burst number counters
`define LGEN_CWL  16
`define LGEN_CWN  16
// event sources: software on bit 0, external lines above
`define LGEN_EW   5
// cpu address
`define LGEN_AW   11

// control, interrupts and event select
`define LGEN_REG_CTL      11'h000
`define LGEN_REG_IRQ_ENA  11'h008
`define LGEN_REG_IRQ_STS  11'h00c
`define LGEN_REG_SEL_RST  11'h010
`define LGEN_REG_SEL_STR  11'h014
`define LGEN_REG_SEL_STP  11'h018
`define LGEN_REG_SEL_TRG  11'h01c
// playback
`define LGEN_REG_SIZ      11'h020
`define LGEN_REG_OFF      11'h024
`define LGEN_REG_STE      11'h028
// burst mode and status
`define LGEN_REG_BMODE    11'h030
`define LGEN_REG_BDL      11'h034
`define LGEN_REG_BLN      11'h038
`define LGEN_REG_BNM      11'h03c
`define LGEN_REG_STS_BLN  11'h040
`define LGEN_REG_STS_BNM  11'h044
// output mask and forced value
`define LGEN_REG_MSK      11'h050
`define LGEN_REG_VAL      11'h054

`endif
